// File: build.f
+incdir+source
source/rv_core_pkg.sv
source/rv_fetch.sv
source/rv_decode.sv
source/rv_regfile.sv
source/rv_execute.sv
source/rv_lsu.sv
source/rv_core.sv
verification/rv_core_chk.sv
verification/rv_core_tb.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - include_dirs:
      - source
    files:
      - source/rv_core_pkg.sv
      - source/rv_fetch.sv
      - source/rv_decode.sv
      - source/rv_regfile.sv
      - source/rv_execute.sv
      - source/rv_lsu.sv
      - source/rv_core.sv
  - target: test
    include_dirs:
      - source
    files:
      - verification/rv_core_chk.sv
      - verification/rv_core_tb.sv

// File: verification/rv_core_tb.sv
`timescale 1ns/1ns
`include "rv_core_consts.svh"

module rv_core_tb;
	localparam int NROWS     = 6;
	localparam int MAXI      = 20;
	localparam int MAXS      = 8;
	localparam int MAX_DLY   = 4;
	localparam int RAM_WORDS = 256;

	logic                clock = 1'b0;
	logic                rst_n_i;
	logic [`RV_XLEN-1:0] inst_addr_r_addr_o;
	logic                inst_addr_r_valid_o;
	logic                inst_addr_r_ready_i;
	logic [`RV_XLEN-1:0] inst_i;
	logic                inst_r_valid_i;
	logic                inst_r_ready_o;
	logic [`RV_XLEN-1:0] data_addr_r_addr_o;
	logic                data_addr_r_valid_o;
	logic                data_addr_r_ready_i;
	logic [`RV_XLEN-1:0] data_r_data_i;
	logic                data_r_valid_i;
	logic                data_r_ready_o;
	logic [`RV_XLEN-1:0] data_addr_w_addr_o;
	logic                data_addr_w_valid_o;
	logic                data_addr_w_ready_i;
	logic [`RV_XLEN-1:0] data_w_data_o;
	logic                data_w_valid_o;
	logic                data_w_ready_i;
	logic                data_bkwd_valid_i;
	logic                data_bkwd_ready_o;
	logic                commit_valid_o;
	logic [`RV_XLEN-1:0] commit_pc_o;

	// program table, one row per program
	logic [31:0] prog_tab [NROWS][MAXI];
	int          n_instr [NROWS];
	bit          rnd_tab [NROWS];
	logic [31:0] st_addr_tab [NROWS][MAXS];
	logic [31:0] st_data_tab [NROWS][MAXS];
	int          n_st [NROWS];
	logic [31:0] pc_tab [NROWS][MAXI];
	int          n_pc [NROWS];

	logic [31:0] rom [MAXI];
	logic [31:0] ram [RAM_WORDS];
	logic [31:0] st_addr_log [$];
	logic [31:0] st_data_log [$];
	logic [31:0] pc_log [$];

	bit          rnd_q;
	int          cycle_cnt;
	int          cycle_limit;
	int          ia_dly;
	int          id_dly;
	int          ra_dly;
	int          rd_dly;
	int          aw_dly;
	int          w_dly;
	int          b_dly;
	bit          id_pend;
	bit          rd_pend;
	bit          b_pend;
	bit          aw_got;
	bit          w_got;
	logic [31:0] id_addr;
	logic [31:0] rd_addr;
	logic [31:0] aw_addr_q;
	logic [31:0] w_data_q;

	rv_core i_dut (.*);

	always #2 clock = ~clock;

	function automatic int next_delay();
		return rnd_q ? int'($urandom_range(0, MAX_DLY)) : 0;
	endfunction

	// memory pattern over the whole byte address
	function automatic logic [31:0] fill_word(int idx);
		logic [31:0] addr;
		addr = idx * 4;
		return (addr * 32'h9E37_79B9) ^ 32'h5A5A_0000 ^ addr;
	endfunction

	function automatic logic [31:0] enc_i(logic [6:0] opc, int rd, int f3, int rs1, int imm);
		logic [31:0] v;
		v = imm;
		return {v[11:0], 5'(rs1), 3'(f3), 5'(rd), opc};
	endfunction

	function automatic logic [31:0] enc_r(int f7, int rs2, int rs1, int f3, int rd);
		return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), rv_core_pkg::OPC_OP};
	endfunction

	function automatic logic [31:0] enc_s(int rs2, int rs1, int imm);
		logic [31:0] v;
		v = imm;
		return {v[11:5], 5'(rs2), 5'(rs1), 3'b010, v[4:0], rv_core_pkg::OPC_STORE};
	endfunction

	function automatic logic [31:0] enc_b(int f3, int rs1, int rs2, int imm);
		logic [31:0] v;
		v = imm;
		return {v[12], v[10:5], 5'(rs2), 5'(rs1), 3'(f3), v[4:1], v[11],
			rv_core_pkg::OPC_BRANCH};
	endfunction

	function automatic logic [31:0] enc_j(int rd, int imm);
		logic [31:0] v;
		v = imm;
		return {v[20], v[10:1], v[11], v[19:12], 5'(rd), rv_core_pkg::OPC_JAL};
	endfunction

	task automatic emit(int r, logic [31:0] w);
		prog_tab[r][n_instr[r]] = w;
		n_instr[r]++;
	endtask

	task automatic expect_store(int r, logic [31:0] a, logic [31:0] d);
		st_addr_tab[r][n_st[r]] = a;
		st_data_tab[r][n_st[r]] = d;
		n_st[r]++;
	endtask

	task automatic expect_pc(int r, logic [31:0] pc);
		pc_tab[r][n_pc[r]] = pc;
		n_pc[r]++;
	endtask

	task automatic build_table();
		int a;
		int b;
		int total;
		int br_pcs [10];
		a = 100;
		b = -7;
		total = 0;
		// row 0: alu ops and immediates
		emit(0, enc_i(rv_core_pkg::OPC_OP_IMM, 1, 0, 0, a));
		emit(0, enc_i(rv_core_pkg::OPC_OP_IMM, 2, 0, 0, b));
		emit(0, enc_r(0, 2, 1, 0, 3));
		emit(0, enc_r(32, 2, 1, 0, 4));
		emit(0, enc_r(0, 2, 1, 7, 5));
		emit(0, enc_r(0, 2, 1, 6, 6));
		emit(0, enc_r(0, 2, 1, 4, 7));
		emit(0, {20'h12345, 5'd8, rv_core_pkg::OPC_LUI});
		emit(0, enc_i(rv_core_pkg::OPC_OP_IMM, 0, 0, 1, 5));
		for (int k = 0; k < 7; k++) begin
			emit(0, enc_s(k == 6 ? 0 : k + 3, 0, 256 + 4 * k));
		end
		emit(0, enc_j(0, 0));
		expect_store(0, 256, 32'(a + b));
		expect_store(0, 260, 32'(a - b));
		expect_store(0, 264, 32'(a & b));
		expect_store(0, 268, 32'(a | b));
		expect_store(0, 272, 32'(a ^ b));
		expect_store(0, 276, 32'h12345 << 12);
		expect_store(0, 280, 32'h0);
		for (int k = 0; k < 17; k++) begin
			expect_pc(0, 4 * k);
		end
		// row 1: loads from preloaded words
		emit(1, enc_i(rv_core_pkg::OPC_LOAD, 1, 2, 0, 'h40));
		emit(1, enc_i(rv_core_pkg::OPC_LOAD, 2, 2, 0, 'h44));
		emit(1, enc_r(0, 2, 1, 0, 3));
		emit(1, enc_s(3, 0, 'h80));
		emit(1, enc_j(0, 0));
		expect_store(1, 'h80, fill_word('h40 / 4) + fill_word('h44 / 4));
		for (int k = 0; k < 5; k++) begin
			expect_pc(1, 4 * k);
		end
		// row 2: branches taken and not taken, then jal
		emit(2, enc_i(rv_core_pkg::OPC_OP_IMM, 1, 0, 0, 5));
		emit(2, enc_i(rv_core_pkg::OPC_OP_IMM, 2, 0, 0, 5));
		emit(2, enc_b(0, 1, 2, 8));
		emit(2, enc_i(rv_core_pkg::OPC_OP_IMM, 3, 0, 0, 1));
		emit(2, enc_b(1, 1, 2, 8));
		emit(2, enc_b(0, 1, 0, 8));
		emit(2, enc_b(1, 1, 0, 8));
		emit(2, enc_i(rv_core_pkg::OPC_OP_IMM, 3, 0, 0, 2));
		emit(2, enc_j(5, 8));
		emit(2, enc_i(rv_core_pkg::OPC_OP_IMM, 3, 0, 0, 3));
		emit(2, enc_s(5, 0, 'h90));
		emit(2, enc_s(3, 0, 'h94));
		emit(2, enc_j(0, 0));
		expect_store(2, 'h90, 32 + 4);
		expect_store(2, 'h94, 0);
		// taken branches skip 12 and 28, the jal skips 36
		br_pcs = '{0, 4, 8, 16, 20, 24, 32, 40, 44, 48};
		foreach (br_pcs[k]) begin
			expect_pc(2, br_pcs[k]);
		end
		// rows 3 to 5 repeat 0 to 2 under random stalls
		for (int r = 3; r < NROWS; r++) begin
			prog_tab[r] = prog_tab[r - 3];
			n_instr[r] = n_instr[r - 3];
			st_addr_tab[r] = st_addr_tab[r - 3];
			st_data_tab[r] = st_data_tab[r - 3];
			n_st[r] = n_st[r - 3];
			pc_tab[r] = pc_tab[r - 3];
			n_pc[r] = n_pc[r - 3];
			rnd_tab[r] = 1'b1;
		end
		for (int r = 0; r < NROWS; r++) begin
			total += n_instr[r];
		end
		cycle_limit = 64 * total * MAX_DLY + NROWS * 16;
	endtask

	task automatic compare(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			$display("*** FAILED ***");
			$fatal(1);
		end
	endtask

	task automatic apply_reset();
		@(posedge clock);
		rst_n_i <= 1'b0;
		for (int i = 0; i < 10; i++) begin
			@(negedge clock);
			if (i > 0) begin
				compare("inst_addr_r_valid_o", inst_addr_r_valid_o, 0);
				compare("inst_r_ready_o", inst_r_ready_o, 0);
				compare("data_addr_r_valid_o", data_addr_r_valid_o, 0);
				compare("data_r_ready_o", data_r_ready_o, 0);
				compare("data_addr_w_valid_o", data_addr_w_valid_o, 0);
				compare("data_w_valid_o", data_w_valid_o, 0);
				compare("data_bkwd_ready_o", data_bkwd_ready_o, 0);
				compare("commit_valid_o", commit_valid_o, 0);
			end
		end
		@(posedge clock);
		rst_n_i <= 1'b1;
	endtask

	always @(posedge clock) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("timeout: the core did not finish its programs in %0d cycles", cycle_limit);
			$display("*** FAILED ***");
			$fatal(1);
		end
	end

	// stop at the first failed handshake assertion
	always @(negedge clock) begin
		if (i_dut.i_chk.fail_cnt != 0) begin
			$display("a bound handshake assertion on the core failed");
			$display("*** FAILED ***");
			$fatal(1);
		end
	end

	// instruction memory model
	always @(posedge clock) begin
		if (!rst_n_i) begin
			inst_addr_r_ready_i <= 1'b0;
			inst_r_valid_i      <= 1'b0;
			id_pend             <= 1'b0;
			ia_dly              <= 0;
		end else begin
			if (inst_addr_r_valid_o && inst_addr_r_ready_i) begin
				inst_addr_r_ready_i <= 1'b0;
				ia_dly              <= next_delay();
				id_dly              <= next_delay();
				id_addr             <= inst_addr_r_addr_o;
				id_pend             <= 1'b1;
			end else if (inst_addr_r_valid_o) begin
				if (ia_dly == 0) begin
					inst_addr_r_ready_i <= 1'b1;
				end else begin
					ia_dly <= ia_dly - 1;
				end
			end
			if (inst_r_valid_i && inst_r_ready_o) begin
				inst_r_valid_i <= 1'b0;
			end else if (id_pend) begin
				if (id_dly == 0) begin
					inst_r_valid_i <= 1'b1;
					inst_i         <= (id_addr / 4 < MAXI) ? rom[id_addr / 4] : 32'h0;
					id_pend        <= 1'b0;
				end else begin
					id_dly <= id_dly - 1;
				end
			end
		end
	end

	// data read channels
	always @(posedge clock) begin
		if (!rst_n_i) begin
			data_addr_r_ready_i <= 1'b0;
			data_r_valid_i      <= 1'b0;
			rd_pend             <= 1'b0;
			ra_dly              <= 0;
		end else begin
			if (data_addr_r_valid_o && data_addr_r_ready_i) begin
				data_addr_r_ready_i <= 1'b0;
				ra_dly              <= next_delay();
				rd_dly              <= next_delay();
				rd_addr             <= data_addr_r_addr_o;
				rd_pend             <= 1'b1;
			end else if (data_addr_r_valid_o) begin
				if (ra_dly == 0) begin
					data_addr_r_ready_i <= 1'b1;
				end else begin
					ra_dly <= ra_dly - 1;
				end
			end
			if (data_r_valid_i && data_r_ready_o) begin
				data_r_valid_i <= 1'b0;
			end else if (rd_pend) begin
				if (rd_dly == 0) begin
					data_r_valid_i <= 1'b1;
					data_r_data_i  <= ram[rd_addr[9:2]];
					rd_pend        <= 1'b0;
				end else begin
					rd_dly <= rd_dly - 1;
				end
			end
		end
	end

	// data write channels, every completed write is logged
	always @(posedge clock) begin : data_write
		bit          got_a;
		bit          got_d;
		logic [31:0] a;
		logic [31:0] d;
		if (!rst_n_i) begin
			data_addr_w_ready_i <= 1'b0;
			data_w_ready_i      <= 1'b0;
			data_bkwd_valid_i   <= 1'b0;
			aw_got              <= 1'b0;
			w_got               <= 1'b0;
			b_pend              <= 1'b0;
			aw_dly              <= 0;
			w_dly               <= 0;
		end else begin
			got_a = aw_got || (data_addr_w_valid_o && data_addr_w_ready_i);
			got_d = w_got || (data_w_valid_o && data_w_ready_i);
			a = aw_got ? aw_addr_q : data_addr_w_addr_o;
			d = w_got ? w_data_q : data_w_data_o;
			if (data_addr_w_valid_o && data_addr_w_ready_i) begin
				data_addr_w_ready_i <= 1'b0;
				aw_dly              <= next_delay();
			end else if (data_addr_w_valid_o) begin
				if (aw_dly == 0) begin
					data_addr_w_ready_i <= 1'b1;
				end else begin
					aw_dly <= aw_dly - 1;
				end
			end
			if (data_w_valid_o && data_w_ready_i) begin
				data_w_ready_i <= 1'b0;
				w_dly          <= next_delay();
			end else if (data_w_valid_o) begin
				if (w_dly == 0) begin
					data_w_ready_i <= 1'b1;
				end else begin
					w_dly <= w_dly - 1;
				end
			end
			if (got_a && got_d) begin
				ram[a[9:2]] = d;
				st_addr_log.push_back(a);
				st_data_log.push_back(d);
				aw_got <= 1'b0;
				w_got  <= 1'b0;
				b_pend <= 1'b1;
				b_dly  <= next_delay();
			end else begin
				aw_got    <= got_a;
				w_got     <= got_d;
				aw_addr_q <= a;
				w_data_q  <= d;
			end
			if (data_bkwd_valid_i && data_bkwd_ready_o) begin
				data_bkwd_valid_i <= 1'b0;
			end else if (b_pend) begin
				if (b_dly == 0) begin
					data_bkwd_valid_i <= 1'b1;
					b_pend            <= 1'b0;
				end else begin
					b_dly <= b_dly - 1;
				end
			end
		end
	end

	always @(posedge clock) begin
		if (rst_n_i && commit_valid_o) begin
			pc_log.push_back(commit_pc_o);
		end
	end

	initial begin
		rst_n_i             = 1'b0;
		inst_addr_r_ready_i = 1'b0;
		inst_i              = '0;
		inst_r_valid_i      = 1'b0;
		data_addr_r_ready_i = 1'b0;
		data_r_data_i       = '0;
		data_r_valid_i      = 1'b0;
		data_addr_w_ready_i = 1'b0;
		data_w_ready_i      = 1'b0;
		data_bkwd_valid_i   = 1'b0;
		cycle_cnt           = 0;
		cycle_limit         = 1000;
		void'($urandom(33));
		build_table();
		for (int r = 0; r < NROWS; r++) begin
			rnd_q = rnd_tab[r];
			for (int k = 0; k < MAXI; k++) begin
				rom[k] = (k < n_instr[r]) ? prog_tab[r][k] : 32'h0;
			end
			for (int k = 0; k < RAM_WORDS; k++) begin
				ram[k] = fill_word(k);
			end
			apply_reset();
			st_addr_log.delete();
			st_data_log.delete();
			pc_log.delete();
			while (!inst_addr_r_valid_o) begin
				@(negedge clock);
			end
			compare("inst_addr_r_addr_o", inst_addr_r_addr_o, `RV_RESET_PC);
			while (pc_log.size() < n_pc[r]) begin
				@(negedge clock);
			end
			compare("store count", st_addr_log.size(), n_st[r]);
			for (int k = 0; k < n_st[r]; k++) begin
				compare("data_addr_w_addr_o", st_addr_log[k], st_addr_tab[r][k]);
				compare("data_w_data_o", st_data_log[k], st_data_tab[r][k]);
			end
			for (int k = 0; k < n_pc[r]; k++) begin
				compare("commit_pc_o", pc_log[k], pc_tab[r][k]);
			end
		end
		if (i_dut.i_chk.fail_cnt == 0) begin
			$display("*** PASSED ***");
			$finish;
		end else begin
			$display("a bound handshake assertion on the core failed");
			$display("*** FAILED ***");
			$fatal(1);
		end
	end

endmodule

// File: verification/rv_core_chk.sv
`timescale 1ns/1ns

module rv_core_chk (
	input logic        clock,
	input logic        rst_n_i,
	input logic        ia_valid_i,
	input logic        ia_ready_i,
	input logic [31:0] ia_addr_i,
	input logic        ra_valid_i,
	input logic        ra_ready_i,
	input logic [31:0] ra_addr_i,
	input logic        wa_valid_i,
	input logic        wa_ready_i,
	input logic [31:0] wa_addr_i,
	input logic        wd_valid_i,
	input logic        wd_ready_i,
	input logic [31:0] wd_data_i,
	input logic        commit_i
);
	// failed assertions so far
	int unsigned fail_cnt = 0;

	// valid and payload hold until the transfer
	ia_hold: assert property (@(posedge clock) disable iff (!rst_n_i)
		ia_valid_i && !ia_ready_i |=> ia_valid_i && $stable(ia_addr_i))
		else begin
			$error("instruction address dropped before ready");
			fail_cnt++;
		end
	ra_hold: assert property (@(posedge clock) disable iff (!rst_n_i)
		ra_valid_i && !ra_ready_i |=> ra_valid_i && $stable(ra_addr_i))
		else begin
			$error("data read address dropped before ready");
			fail_cnt++;
		end
	wa_hold: assert property (@(posedge clock) disable iff (!rst_n_i)
		wa_valid_i && !wa_ready_i |=> wa_valid_i && $stable(wa_addr_i))
		else begin
			$error("data write address dropped before ready");
			fail_cnt++;
		end
	wd_hold: assert property (@(posedge clock) disable iff (!rst_n_i)
		wd_valid_i && !wd_ready_i |=> wd_valid_i && $stable(wd_data_i))
		else begin
			$error("write data dropped before ready");
			fail_cnt++;
		end

	commit_pulse: assert property (@(posedge clock) disable iff (!rst_n_i)
		commit_i |=> !commit_i)
		else begin
			$error("commit lasted more than one cycle");
			fail_cnt++;
		end

	// one cycle of reset lets the state settle
	quiet_in_reset: assert property (@(posedge clock)
		!rst_n_i && $past(!rst_n_i) |-> !(ia_valid_i || ra_valid_i || wa_valid_i ||
		wd_valid_i || commit_i))
		else begin
			$error("valid or commit high during reset");
			fail_cnt++;
		end

endmodule

bind rv_core rv_core_chk i_chk (
	.clock      (clock),
	.rst_n_i    (rst_n_i),
	.ia_valid_i (inst_addr_r_valid_o),
	.ia_ready_i (inst_addr_r_ready_i),
	.ia_addr_i  (inst_addr_r_addr_o),
	.ra_valid_i (data_addr_r_valid_o),
	.ra_ready_i (data_addr_r_ready_i),
	.ra_addr_i  (data_addr_r_addr_o),
	.wa_valid_i (data_addr_w_valid_o),
	.wa_ready_i (data_addr_w_ready_i),
	.wa_addr_i  (data_addr_w_addr_o),
	.wd_valid_i (data_w_valid_o),
	.wd_ready_i (data_w_ready_i),
	.wd_data_i  (data_w_data_o),
	.commit_i   (commit_valid_o)
);

// File: source/rv_core.sv
`timescale 1ns/1ns
`include "rv_core_consts.svh"

module rv_core (
	input  logic                clock,
	input  logic                rst_n_i,
	// instruction channels
	output logic [`RV_XLEN-1:0] inst_addr_r_addr_o,
	output logic                inst_addr_r_valid_o,
	input  logic                inst_addr_r_ready_i,
	input  logic [`RV_XLEN-1:0] inst_i,
	input  logic                inst_r_valid_i,
	output logic                inst_r_ready_o,
	// data read
	output logic [`RV_XLEN-1:0] data_addr_r_addr_o,
	output logic                data_addr_r_valid_o,
	input  logic                data_addr_r_ready_i,
	input  logic [`RV_XLEN-1:0] data_r_data_i,
	input  logic                data_r_valid_i,
	output logic                data_r_ready_o,
	// data write and response
	output logic [`RV_XLEN-1:0] data_addr_w_addr_o,
	output logic                data_addr_w_valid_o,
	input  logic                data_addr_w_ready_i,
	output logic [`RV_XLEN-1:0] data_w_data_o,
	output logic                data_w_valid_o,
	input  logic                data_w_ready_i,
	input  logic                data_bkwd_valid_i,
	output logic                data_bkwd_ready_o,
	// retire trace
	output logic                commit_valid_o,
	output logic [`RV_XLEN-1:0] commit_pc_o
);
	logic [`RV_XLEN-1:0]  instr_q;
	logic [`RV_XLEN-1:0]  pc_q;
	logic                 exec_valid;
	logic [4:0]           rs1;
	logic [4:0]           rs2;
	logic [4:0]           rd;
	logic [`RV_XLEN-1:0]  imm;
	rv_core_pkg::alu_op_e alu_op;
	logic                 use_imm;
	rv_core_pkg::mem_op_e mem_op;
	rv_core_pkg::br_op_e  br_op;
	logic                 reg_wen;
	logic [`RV_XLEN-1:0]  rs1_val;
	logic [`RV_XLEN-1:0]  rs2_val;
	logic [`RV_XLEN-1:0]  result;
	logic [`RV_XLEN-1:0]  next_pc;
	logic                 rf_wen;
	logic [4:0]           rf_waddr;
	logic [`RV_XLEN-1:0]  rf_wdata;
	logic                 commit_pulse;

	rv_fetch i_fetch (
		.clock               (clock),
		.rst_n_i             (rst_n_i),
		.inst_addr_r_addr_o  (inst_addr_r_addr_o),
		.inst_addr_r_valid_o (inst_addr_r_valid_o),
		.inst_addr_r_ready_i (inst_addr_r_ready_i),
		.inst_i              (inst_i),
		.inst_r_valid_i      (inst_r_valid_i),
		.inst_r_ready_o      (inst_r_ready_o),
		.next_pc_i           (next_pc),
		.mem_op_i            (mem_op),
		.commit_i            (commit_pulse),
		.instr_o             (instr_q),
		.pc_o                (pc_q),
		.exec_valid_o        (exec_valid)
	);

	rv_decode i_decode (
		.instr_i   (instr_q),
		.rs1_o     (rs1),
		.rs2_o     (rs2),
		.rd_o      (rd),
		.imm_o     (imm),
		.alu_op_o  (alu_op),
		.use_imm_o (use_imm),
		.mem_op_o  (mem_op),
		.br_op_o   (br_op),
		.reg_wen_o (reg_wen)
	);

	rv_regfile i_regfile (
		.clock    (clock),
		.rst_n_i  (rst_n_i),
		.raddr1_i (rs1),
		.raddr2_i (rs2),
		.rdata1_o (rs1_val),
		.rdata2_o (rs2_val),
		.wen_i    (rf_wen),
		.waddr_i  (rf_waddr),
		.wdata_i  (rf_wdata)
	);

	rv_execute i_execute (
		.pc_i      (pc_q),
		.rs1_val_i (rs1_val),
		.rs2_val_i (rs2_val),
		.imm_i     (imm),
		.alu_op_i  (alu_op),
		.use_imm_i (use_imm),
		.br_op_i   (br_op),
		.result_o  (result),
		.next_pc_o (next_pc)
	);

	// store data comes straight from rs2
	rv_lsu i_lsu (
		.clock               (clock),
		.rst_n_i             (rst_n_i),
		.exec_valid_i        (exec_valid),
		.mem_op_i            (mem_op),
		.result_i            (result),
		.store_data_i        (rs2_val),
		.rd_i                (rd),
		.reg_wen_i           (reg_wen),
		.pc_i                (pc_q),
		.data_addr_r_addr_o  (data_addr_r_addr_o),
		.data_addr_r_valid_o (data_addr_r_valid_o),
		.data_addr_r_ready_i (data_addr_r_ready_i),
		.data_r_data_i       (data_r_data_i),
		.data_r_valid_i      (data_r_valid_i),
		.data_r_ready_o      (data_r_ready_o),
		.data_addr_w_addr_o  (data_addr_w_addr_o),
		.data_addr_w_valid_o (data_addr_w_valid_o),
		.data_addr_w_ready_i (data_addr_w_ready_i),
		.data_w_data_o       (data_w_data_o),
		.data_w_valid_o      (data_w_valid_o),
		.data_w_ready_i      (data_w_ready_i),
		.data_bkwd_valid_i   (data_bkwd_valid_i),
		.data_bkwd_ready_o   (data_bkwd_ready_o),
		.rf_wen_o            (rf_wen),
		.rf_waddr_o          (rf_waddr),
		.rf_wdata_o          (rf_wdata),
		.commit_o            (commit_pulse),
		.commit_pc_o         (commit_pc_o)
	);

	assign commit_valid_o = commit_pulse;

endmodule

// File: source/rv_lsu.sv
`timescale 1ns/1ns
`include "rv_core_consts.svh"

module rv_lsu (
	input  logic                 clock,
	input  logic                 rst_n_i,
	input  logic                 exec_valid_i,
	input  rv_core_pkg::mem_op_e mem_op_i,
	input  logic [`RV_XLEN-1:0]  result_i,
	input  logic [`RV_XLEN-1:0]  store_data_i,
	input  logic [4:0]           rd_i,
	input  logic                 reg_wen_i,
	input  logic [`RV_XLEN-1:0]  pc_i,
	output logic [`RV_XLEN-1:0]  data_addr_r_addr_o,
	output logic                 data_addr_r_valid_o,
	input  logic                 data_addr_r_ready_i,
	input  logic [`RV_XLEN-1:0]  data_r_data_i,
	input  logic                 data_r_valid_i,
	output logic                 data_r_ready_o,
	output logic [`RV_XLEN-1:0]  data_addr_w_addr_o,
	output logic                 data_addr_w_valid_o,
	input  logic                 data_addr_w_ready_i,
	output logic [`RV_XLEN-1:0]  data_w_data_o,
	output logic                 data_w_valid_o,
	input  logic                 data_w_ready_i,
	input  logic                 data_bkwd_valid_i,
	output logic                 data_bkwd_ready_o,
	output logic                 rf_wen_o,
	output logic [4:0]           rf_waddr_o,
	output logic [`RV_XLEN-1:0]  rf_wdata_o,
	output logic                 commit_o,
	output logic [`RV_XLEN-1:0]  commit_pc_o
);
	typedef enum logic [2:0] {
		L_IDLE,
		L_RADDR,
		L_RDATA,
		L_WRITE,
		L_BRESP,
		L_COMMIT
	} lsu_state_e;

	lsu_state_e          state_q;
	logic                aw_pend_q;
	logic                w_pend_q;
	logic                aw_done;
	logic                w_done;
	logic [`RV_XLEN-1:0] addr_q;
	logic [`RV_XLEN-1:0] wdata_q;
	logic [`RV_XLEN-1:0] value_q;
	logic [`RV_XLEN-1:0] pc_q;
	logic [4:0]          rd_q;
	logic                wen_q;

	// address and data halves of a write finish independently
	assign aw_done = !aw_pend_q || data_addr_w_ready_i;
	assign w_done  = !w_pend_q || data_w_ready_i;

	always_ff @(posedge clock) begin
		if (!rst_n_i) begin
			state_q   <= L_IDLE;
			aw_pend_q <= 1'b0;
			w_pend_q  <= 1'b0;
		end else begin
			case (state_q)
				L_IDLE: begin
					if (exec_valid_i) begin
						case (mem_op_i)
							rv_core_pkg::MEM_LOAD: state_q <= L_RADDR;
							rv_core_pkg::MEM_STORE: begin
								state_q   <= L_WRITE;
								aw_pend_q <= 1'b1;
								w_pend_q  <= 1'b1;
							end
							default: state_q <= L_COMMIT;
						endcase
					end
				end
				L_RADDR: begin
					if (data_addr_r_ready_i) begin
						state_q <= L_RDATA;
					end
				end
				L_RDATA: begin
					if (data_r_valid_i) begin
						state_q <= L_COMMIT;
					end
				end
				L_WRITE: begin
					if (data_addr_w_ready_i) begin
						aw_pend_q <= 1'b0;
					end
					if (data_w_ready_i) begin
						w_pend_q <= 1'b0;
					end
					if (aw_done && w_done) begin
						state_q <= L_BRESP;
					end
				end
				L_BRESP: begin
					if (data_bkwd_valid_i) begin
						state_q <= L_COMMIT;
					end
				end
				default: state_q <= L_IDLE;
			endcase
		end
	end

	// capture in EXEC, load data replaces the alu result
	always_ff @(posedge clock) begin
		if (state_q == L_IDLE && exec_valid_i) begin
			addr_q  <= result_i;
			value_q <= result_i;
			wdata_q <= store_data_i;
			pc_q    <= pc_i;
			rd_q    <= rd_i;
			wen_q   <= reg_wen_i;
		end else if (state_q == L_RDATA && data_r_valid_i) begin
			value_q <= data_r_data_i;
		end
	end

	assign data_addr_r_addr_o  = addr_q;
	assign data_addr_r_valid_o = (state_q == L_RADDR);
	assign data_r_ready_o      = (state_q == L_RDATA);
	assign data_addr_w_addr_o  = addr_q;
	assign data_addr_w_valid_o = aw_pend_q;
	assign data_w_data_o       = wdata_q;
	assign data_w_valid_o      = w_pend_q;
	assign data_bkwd_ready_o   = (state_q == L_BRESP);

	assign commit_o    = (state_q == L_COMMIT);
	assign commit_pc_o = pc_q;
	assign rf_wen_o    = commit_o && wen_q;
	assign rf_waddr_o  = rd_q;
	assign rf_wdata_o  = value_q;

endmodule

// File: source/rv_execute.sv
`timescale 1ns/1ns
`include "rv_core_consts.svh"

module rv_execute (
	input  logic [`RV_XLEN-1:0]  pc_i,
	input  logic [`RV_XLEN-1:0]  rs1_val_i,
	input  logic [`RV_XLEN-1:0]  rs2_val_i,
	input  logic [`RV_XLEN-1:0]  imm_i,
	input  rv_core_pkg::alu_op_e alu_op_i,
	input  logic                 use_imm_i,
	input  rv_core_pkg::br_op_e  br_op_i,
	output logic [`RV_XLEN-1:0]  result_o,
	output logic [`RV_XLEN-1:0]  next_pc_o
);
	logic [`RV_XLEN-1:0] op_b;
	logic [`RV_XLEN-1:0] pc_plus4;
	logic                taken;

	assign op_b     = use_imm_i ? imm_i : rs2_val_i;
	assign pc_plus4 = pc_i + `RV_XLEN'(4);

	always_comb begin
		case (alu_op_i)
			rv_core_pkg::ALU_ADD:    result_o = rs1_val_i + op_b;
			rv_core_pkg::ALU_SUB:    result_o = rs1_val_i - op_b;
			rv_core_pkg::ALU_AND:    result_o = rs1_val_i & op_b;
			rv_core_pkg::ALU_OR:     result_o = rs1_val_i | op_b;
			rv_core_pkg::ALU_XOR:    result_o = rs1_val_i ^ op_b;
			rv_core_pkg::ALU_PASS_B: result_o = op_b;
			default:                 result_o = '0;
		endcase
		// link value for jal
		if (br_op_i == rv_core_pkg::BR_JAL) begin
			result_o = pc_plus4;
		end
	end

	always_comb begin
		case (br_op_i)
			rv_core_pkg::BR_BEQ: taken = (rs1_val_i == rs2_val_i);
			rv_core_pkg::BR_BNE: taken = (rs1_val_i != rs2_val_i);
			rv_core_pkg::BR_JAL: taken = 1'b1;
			default:             taken = 1'b0;
		endcase
	end

	assign next_pc_o = taken ? pc_i + imm_i : pc_plus4;

endmodule

// File: source/rv_regfile.sv
`timescale 1ns/1ns
`include "rv_core_consts.svh"

module rv_regfile (
	input  logic                         clock,
	input  logic                         rst_n_i,
	input  logic [$clog2(`RV_NREGS)-1:0] raddr1_i,
	input  logic [$clog2(`RV_NREGS)-1:0] raddr2_i,
	output logic [`RV_XLEN-1:0]          rdata1_o,
	output logic [`RV_XLEN-1:0]          rdata2_o,
	input  logic                         wen_i,
	input  logic [$clog2(`RV_NREGS)-1:0] waddr_i,
	input  logic [`RV_XLEN-1:0]          wdata_i
);
	logic [`RV_XLEN-1:0] regs_q [`RV_NREGS];

	// x0 is cleared by reset and never written afterwards
	always_ff @(posedge clock) begin
		if (!rst_n_i) begin
			regs_q <= '{default: '0};
		end else if (wen_i && waddr_i != '0) begin
			regs_q[waddr_i] <= wdata_i;
		end
	end

	assign rdata1_o = regs_q[raddr1_i];
	assign rdata2_o = regs_q[raddr2_i];

endmodule

// File: source/rv_decode.sv
`timescale 1ns/1ns
`include "rv_core_consts.svh"

module rv_decode (
	input  logic [`RV_XLEN-1:0]  instr_i,
	output logic [4:0]           rs1_o,
	output logic [4:0]           rs2_o,
	output logic [4:0]           rd_o,
	output logic [`RV_XLEN-1:0]  imm_o,
	output rv_core_pkg::alu_op_e alu_op_o,
	output logic                 use_imm_o,
	output rv_core_pkg::mem_op_e mem_op_o,
	output rv_core_pkg::br_op_e  br_op_o,
	output logic                 reg_wen_o
);
	logic [6:0]          opcode;
	logic [2:0]          funct3;
	logic [6:0]          funct7;
	logic [`RV_XLEN-1:0] imm_i_type;
	logic [`RV_XLEN-1:0] imm_s_type;
	logic [`RV_XLEN-1:0] imm_b_type;
	logic [`RV_XLEN-1:0] imm_u_type;
	logic [`RV_XLEN-1:0] imm_j_type;

	assign opcode = instr_i[6:0];
	assign funct3 = instr_i[14:12];
	assign funct7 = instr_i[31:25];
	assign rs1_o  = instr_i[19:15];
	assign rs2_o  = instr_i[24:20];
	assign rd_o   = instr_i[11:7];

	// sign-extended immediates, all formats
	assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
	assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
	assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
		instr_i[30:25], instr_i[11:8], 1'b0};
	assign imm_u_type = {instr_i[31:12], 12'h000};
	assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
		instr_i[20], instr_i[30:21], 1'b0};

	always_comb begin
		// anything unrecognised falls out as a no-op
		alu_op_o  = rv_core_pkg::ALU_ADD;
		use_imm_o = 1'b0;
		mem_op_o  = rv_core_pkg::MEM_NONE;
		br_op_o   = rv_core_pkg::BR_NONE;
		reg_wen_o = 1'b0;
		imm_o     = imm_i_type;
		case (opcode)
			rv_core_pkg::OPC_OP_IMM: begin
				use_imm_o = 1'b1;
				reg_wen_o = (funct3 == 3'b000);
			end
			rv_core_pkg::OPC_OP: begin
				reg_wen_o = 1'b1;
				case ({funct7, funct3})
					10'b0000000_000: alu_op_o = rv_core_pkg::ALU_ADD;
					10'b0100000_000: alu_op_o = rv_core_pkg::ALU_SUB;
					10'b0000000_111: alu_op_o = rv_core_pkg::ALU_AND;
					10'b0000000_110: alu_op_o = rv_core_pkg::ALU_OR;
					10'b0000000_100: alu_op_o = rv_core_pkg::ALU_XOR;
					default:         reg_wen_o = 1'b0;
				endcase
			end
			rv_core_pkg::OPC_LUI: begin
				alu_op_o  = rv_core_pkg::ALU_PASS_B;
				use_imm_o = 1'b1;
				imm_o     = imm_u_type;
				reg_wen_o = 1'b1;
			end
			rv_core_pkg::OPC_LOAD: begin
				if (funct3 == 3'b010) begin
					use_imm_o = 1'b1;
					mem_op_o  = rv_core_pkg::MEM_LOAD;
					reg_wen_o = 1'b1;
				end
			end
			rv_core_pkg::OPC_STORE: begin
				use_imm_o = 1'b1;
				imm_o     = imm_s_type;
				if (funct3 == 3'b010) begin
					mem_op_o = rv_core_pkg::MEM_STORE;
				end
			end
			rv_core_pkg::OPC_BRANCH: begin
				imm_o = imm_b_type;
				if (funct3 == 3'b000) begin
					br_op_o = rv_core_pkg::BR_BEQ;
				end else if (funct3 == 3'b001) begin
					br_op_o = rv_core_pkg::BR_BNE;
				end
			end
			rv_core_pkg::OPC_JAL: begin
				imm_o     = imm_j_type;
				br_op_o   = rv_core_pkg::BR_JAL;
				reg_wen_o = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

// File: source/rv_fetch.sv
`timescale 1ns/1ns
`include "rv_core_consts.svh"

module rv_fetch (
	input  logic                 clock,
	input  logic                 rst_n_i,
	output logic [`RV_XLEN-1:0]  inst_addr_r_addr_o,
	output logic                 inst_addr_r_valid_o,
	input  logic                 inst_addr_r_ready_i,
	input  logic [`RV_XLEN-1:0]  inst_i,
	input  logic                 inst_r_valid_i,
	output logic                 inst_r_ready_o,
	input  logic [`RV_XLEN-1:0]  next_pc_i,
	input  rv_core_pkg::mem_op_e mem_op_i,
	input  logic                 commit_i,
	output logic [`RV_XLEN-1:0]  instr_o,
	output logic [`RV_XLEN-1:0]  pc_o,
	output logic                 exec_valid_o
);
	typedef enum logic [1:0] {
		F_ADDR,
		F_DATA,
		F_EXEC,
		F_WAIT
	} fetch_state_e;

	fetch_state_e        state_q;
	logic [`RV_XLEN-1:0] pc_q;
	logic [`RV_XLEN-1:0] instr_q;
	logic                started_q;

	// parks in WAIT during reset, first address phase right after
	always_ff @(posedge clock) begin
		if (!rst_n_i) begin
			state_q   <= F_WAIT;
			started_q <= 1'b0;
			pc_q      <= `RV_RESET_PC;
		end else begin
			case (state_q)
				F_ADDR: begin
					if (inst_addr_r_ready_i) begin
						state_q <= F_DATA;
					end
				end
				F_DATA: begin
					if (inst_r_valid_i) begin
						state_q <= F_EXEC;
					end
				end
				F_EXEC: state_q <= F_WAIT;
				default: begin
					if (!started_q) begin
						started_q <= 1'b1;
						state_q   <= F_ADDR;
					end else if (commit_i) begin
						// memory ops never redirect
						pc_q    <= (mem_op_i == rv_core_pkg::MEM_NONE) ?
							next_pc_i : pc_q + `RV_XLEN'(4);
						state_q <= F_ADDR;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state_q == F_DATA && inst_r_valid_i) begin
			instr_q <= inst_i;
		end
	end

	assign inst_addr_r_addr_o  = pc_q;
	assign inst_addr_r_valid_o = (state_q == F_ADDR);
	assign inst_r_ready_o      = (state_q == F_DATA);
	assign exec_valid_o        = (state_q == F_EXEC);
	assign instr_o             = instr_q;
	assign pc_o                = pc_q;

endmodule

// File: source/rv_core_pkg.sv
package rv_core_pkg;

	// RV32I major opcodes in the supported subset
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_PASS_B
	} alu_op_e;

	// whole-word accesses only
	typedef enum logic [1:0] {
		MEM_NONE,
		MEM_LOAD,
		MEM_STORE
	} mem_op_e;

	typedef enum logic [1:0] {
		BR_NONE,
		BR_BEQ,
		BR_BNE,
		BR_JAL
	} br_op_e;

endpackage

// File: source/rv_core_consts.svh
`ifndef RV_CORE_CONSTS_SVH
`define RV_CORE_CONSTS_SVH

// data and address width
`define RV_XLEN 32

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// architectural registers, x0 included
`define RV_NREGS 32

`endif
